//--- rtl/spi_regs_pkg.sv
// spi_regs_pkg
// shared constants for the SPI register block: bus mode, register map,
// slave FSM encoding and the command header layout

package spi_regs_pkg;

	// SPI bus mode, mode 3
	localparam bit spi_cpol = 1'b1;                     // sclk idles high
	localparam bit spi_cpha = 1'b1;                     // sample on trailing edge

	// register map
	localparam int unsigned reg_count = 8;              // byte registers 0..7
	localparam logic [6:0] addr_id = 7'd0;              // read-only id
	localparam logic [6:0] addr_scratch_lo = 7'd1;      // first scratch
	localparam logic [6:0] addr_scratch_hi = 7'd5;      // last scratch
	localparam logic [6:0] addr_gpio_out = 7'd6;        // drives gpio_out pin
	localparam logic [6:0] addr_gpio_in = 7'd7;         // reads gpio_in pin

	localparam logic [7:0] device_id = 8'hA5;           // fixed, not reset dependent

	// byte-level slave FSM
	localparam logic [1:0] st_idle = 2'd0;              // cs high or waiting for cs fall
	localparam logic [1:0] st_wait = 2'd1;              // waiting for next sclk edge
	localparam logic [1:0] st_edge = 2'd2;              // edge seen, bump counter
	localparam logic [1:0] st_done = 2'd3;              // byte complete, rx_valid

	localparam logic [3:0] sclk_edge_last = 4'd15;      // 16 edges per byte

	// first byte of a frame
	// raw view feeds the data path, decoded view is used for the header only
	typedef union packed {
		logic [7:0] raw;                                // byte as shifted in
		struct packed {
			logic       rd;                             // 1 = read, 0 = write
			logic [6:0] addr;                           // start address
		} fld;
	} spi_header_t;

endpackage

//--- rtl/spi_slave.sv
// spi_slave
// byte-level SPI slave: synchronizes cs/sclk/mosi, finds the sample and
// shift edges for the selected mode and moves one byte each way per 16 edges

`timescale 1ns/1ps

module spi_slave #(
	parameter bit cpol = spi_regs_pkg::spi_cpol,        // sclk idle level
	parameter bit cpha = spi_regs_pkg::spi_cpha         // 1 = sample on trailing edge
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       cs,                              // active low select
	input  logic       sclk,
	input  logic       mosi,
	output logic       miso,
	input  logic [7:0] tx_byte,                         // next byte to send
	output logic [7:0] rx_byte,                         // last byte received
	output logic       rx_valid,                        // one cycle per byte
	output logic       frame_start                      // one cycle at cs fall
);

	import spi_regs_pkg::*;

	logic       cs_meta;
	logic       cs_sync;
	logic       cs_d;                                   // previous synced cs
	logic       sclk_meta;
	logic       sclk_sync;
	logic       sclk_d;                                 // previous synced sclk
	logic       mosi_meta;
	logic       mosi_sync;                              // same latency as sclk_sync

	logic [1:0] state;
	logic [3:0] edge_cnt;                               // edges seen in this byte
	logic [7:0] mosi_shift;
	logic [7:0] miso_shift;

	logic       cs_fall;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       lead_edge;
	logic       trail_edge;
	logic       edge_hit;
	logic       sample_now;
	logic       shift_now;

	// two-flop sync plus one history flop for edge detect
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_meta   <= 1'b1;                          // deselected
			cs_sync   <= 1'b1;
			cs_d      <= 1'b1;
			sclk_meta <= cpol;                          // idle level
			sclk_sync <= cpol;
			sclk_d    <= cpol;
		end else begin
			cs_meta   <= cs;
			cs_sync   <= cs_meta;
			cs_d      <= cs_sync;
			sclk_meta <= sclk;
			sclk_sync <= sclk_meta;
			sclk_d    <= sclk_sync;
		end
	end

	always_ff @(posedge sys_clk) begin
		mosi_meta <= mosi;
		mosi_sync <= mosi_meta;                         // stays aligned to sclk_sync
	end

	assign cs_fall    = cs_d & ~cs_sync;
	assign sclk_rise  = ~sclk_d & sclk_sync;
	assign sclk_fall  = sclk_d & ~sclk_sync;
	assign lead_edge  = cpol ? sclk_fall : sclk_rise;   // first edge after idle
	assign trail_edge = cpol ? sclk_rise : sclk_fall;

	// even count expects a leading edge, odd a trailing one
	assign edge_hit   = (state == st_wait) & ~cs_sync & (edge_cnt[0] ? trail_edge : lead_edge);
	assign sample_now = edge_hit & (cpha ? edge_cnt[0] : ~edge_cnt[0]);
	// with cpha the first leading edge only presents bit 7, no shift yet
	assign shift_now  = edge_hit &
		(cpha ? (~edge_cnt[0] & (edge_cnt != 4'd0)) : edge_cnt[0]);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else if (cs_sync) begin
			state <= st_idle;                           // deselect aborts any byte
		end else begin
			case (state)
				st_idle: begin
					if (cs_fall)
						state <= st_wait;
				end
				st_wait: begin
					if (edge_hit)
						state <= (edge_cnt == sclk_edge_last) ? st_done : st_edge;
				end
				st_edge: state <= st_wait;
				st_done: state <= st_wait;              // next byte of the frame
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= 4'd0;
		else if (state == st_idle || state == st_done)
			edge_cnt <= 4'd0;                           // new byte
		else if (state == st_edge)
			edge_cnt <= edge_cnt + 4'd1;
	end

	// receive shifter, msb first
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			mosi_shift <= 8'h00;
		else if (sample_now)
			mosi_shift <= {mosi_shift[6:0], mosi_sync};
	end

	// transmit shifter, reloaded at frame start and after every byte
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			miso_shift <= 8'h00;
		else if (cs_fall || state == st_done)
			miso_shift <= tx_byte;
		else if (shift_now)
			miso_shift <= {miso_shift[6:0], 1'b0};
	end

	assign miso        = ~cs & miso_shift[7];          // no tri-state, held low
	assign rx_byte     = mosi_shift;
	assign rx_valid    = (state == st_done);
	assign frame_start = cs_fall;

endmodule

//--- rtl/spi_frame_ctrl.sv
// spi_frame_ctrl
// frame layer: decodes the command header, keeps the running address,
// issues register writes and picks the byte returned on the next slot

`timescale 1ns/1ps

module spi_frame_ctrl (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       frame_start,
	input  logic       rx_valid,
	input  logic [7:0] rx_byte,
	output logic [7:0] tx_byte,
	output logic       wr_en,
	output logic [6:0] wr_addr,
	output logic [7:0] wr_data,
	output logic [6:0] rd_addr,
	input  logic [7:0] rd_data
);

	import spi_regs_pkg::*;

	spi_header_t hdr;                                   // rx_byte seen both ways
	logic        hdr_phase;                             // next byte is the header
	logic        is_read;                               // latched direction
	logic [6:0]  addr_q;                                // address of current data byte

	assign hdr = rx_byte;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			hdr_phase <= 1'b1;
			is_read   <= 1'b0;
			addr_q    <= 7'd0;
			wr_en     <= 1'b0;
		end else begin
			wr_en <= 1'b0;                              // strobe by default
			if (frame_start) begin
				hdr_phase <= 1'b1;                      // also drops a half frame
			end else if (rx_valid) begin
				if (hdr_phase) begin
					hdr_phase <= 1'b0;
					is_read   <= hdr.fld.rd;
					addr_q    <= hdr.fld.addr;
				end else begin
					addr_q <= addr_q + 7'd1;            // auto increment, wraps at 127
					wr_en  <= ~is_read;
				end
			end
		end
	end

	// write payload, valid with wr_en
	always_ff @(posedge sys_clk) begin
		if (rx_valid && !hdr_phase && !frame_start) begin
			wr_addr <= addr_q;
			wr_data <= hdr.raw;
		end
	end

	// look ahead one byte, the slave reloads its shifter at rx_valid
	assign rd_addr = hdr_phase ? hdr.fld.addr : addr_q + 7'd1;

	always_comb begin
		tx_byte = 8'h00;                                // header slot and writes
		if (frame_start)
			tx_byte = 8'h00;
		else if (hdr_phase)
			tx_byte = (rx_valid && hdr.fld.rd) ? rd_data : 8'h00;  // first read byte
		else if (is_read)
			tx_byte = rd_data;
	end

endmodule

//--- rtl/reg_bank.sv
// reg_bank
// eight byte registers: fixed id, five scratch bytes, gpio output latch
// and a live view of gpio_in; unmapped reads return zero

`timescale 1ns/1ps

module reg_bank (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       wr_en,
	input  logic [6:0] wr_addr,
	input  logic [7:0] wr_data,
	input  logic [6:0] rd_addr,
	output logic [7:0] rd_data,
	input  logic [7:0] gpio_in,
	output logic [7:0] gpio_out
);

	import spi_regs_pkg::*;

	logic [7:0] scratch [addr_scratch_lo:addr_scratch_hi];
	logic [7:0] gpio_out_q;
	logic       wr_scratch;
	logic       rd_scratch;
	logic       rd_mapped;

	assign wr_scratch = (wr_addr >= addr_scratch_lo) && (wr_addr <= addr_scratch_hi);
	assign rd_scratch = (rd_addr >= addr_scratch_lo) && (rd_addr <= addr_scratch_hi);
	assign rd_mapped  = (rd_addr < reg_count);

	// id and gpio_in are read only, writes there just fall through
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = addr_scratch_lo; i <= addr_scratch_hi; i++)
				scratch[i] <= 8'h00;
			gpio_out_q <= 8'h00;
		end else if (wr_en) begin
			if (wr_scratch)
				scratch[wr_addr[2:0]] <= wr_data;
			else if (wr_addr == addr_gpio_out)
				gpio_out_q <= wr_data;
		end
	end

	always_comb begin
		rd_data = 8'h00;                                // above 7 reads zero
		if (rd_mapped) begin
			if (rd_addr == addr_id)
				rd_data = device_id;
			else if (rd_scratch)
				rd_data = scratch[rd_addr[2:0]];
			else if (rd_addr == addr_gpio_out)
				rd_data = gpio_out_q;                   // readback of the latch
			else if (rd_addr == addr_gpio_in)
				rd_data = gpio_in;                      // live pin value
		end
	end

	assign gpio_out = gpio_out_q;

endmodule

//--- rtl/spi_regs_top.sv
// spi_regs_top
// SPI attached register block: byte slave, frame control and register map

`timescale 1ns/1ps

module spi_regs_top (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       cs,
	input  logic       sclk,
	input  logic       mosi,
	output logic       miso,
	input  logic [7:0] gpio_in,
	output logic [7:0] gpio_out
);

	import spi_regs_pkg::*;

	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	logic       rx_valid;
	logic       frame_start;
	logic       wr_en;
	logic [6:0] wr_addr;
	logic [7:0] wr_data;
	logic [6:0] rd_addr;
	logic [7:0] rd_data;

	spi_slave #(
		.cpol (spi_cpol),
		.cpha (spi_cpha)
	) u_spi_slave (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.miso        (miso),
		.tx_byte     (tx_byte),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.frame_start (frame_start)
	);

	spi_frame_ctrl u_spi_frame_ctrl (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.frame_start (frame_start),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.tx_byte     (tx_byte),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

	reg_bank u_reg_bank (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out)
	);

endmodule

//--- dv/spi_regs_assertions.sv
// spi_regs_assertions
// concurrent checks on SPI pins, byte strobes and register writes,
// bound into every spi_regs_top

`timescale 1ns/1ps

module spi_regs_assertions (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic       cs,
	input logic       miso,
	input logic [7:0] gpio_out,
	input logic       rx_valid,
	input logic       wr_en,
	input logic       hdr_phase                     // frame ctrl expects a header
);

	int assert_errors = 0;                          // failed assertion count

	miso_idle_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cs |-> !miso)
	else begin
		$error("miso high while cs is deasserted");
		assert_errors++;
	end

	gpio_out_in_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$changed(gpio_out) |-> !cs)
	else begin
		$error("gpio_out changed outside a frame");
		assert_errors++;
	end

	rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)
	else begin
		$error("rx_valid held for more than one cycle");
		assert_errors++;
	end

	no_write_on_header: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_valid && hdr_phase) |=> !wr_en)
	else begin
		$error("write strobe issued for a header byte");
		assert_errors++;
	end

endmodule

bind spi_regs_top spi_regs_assertions u_assertions (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.cs        (cs),
	.miso      (miso),
	.gpio_out  (gpio_out),
	.rx_valid  (rx_valid),
	.wr_en     (wr_en),
	.hdr_phase (u_spi_frame_ctrl.hdr_phase)
);

//--- dv/tb_spi_regs.sv
// tb_spi_regs
// testbench for the SPI register block: mode 3 master tasks, a register
// reference model and readback checks against it

`timescale 1ns/1ps

module tb_spi_regs;

	import spi_regs_pkg::*;

	localparam int half_period     = 10;            // sclk half period in sys_clk cycles
	localparam int gap_cycles      = 10;            // cs setup, hold and idle gap
	localparam int reset_cycles    = 16;
	localparam int max_frame_bytes = 8;             // header plus seven data bytes
	localparam int frame_count     = 21;            // frames issued by the tests below
	localparam int frame_cycles    = max_frame_bytes * 16 * half_period + 4 * gap_cycles;
	localparam int timeout_cycles  = reset_cycles + frame_count * frame_cycles + 2000;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       cs;
	logic       sclk;
	logic       mosi;
	logic       miso;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;

	logic [7:0] ref_regs [0:reg_count-1];           // expected register contents
	logic [7:0] tx_buf [0:max_frame_bytes-1];       // bytes sent in a frame
	logic [7:0] rx_buf [0:max_frame_bytes-1];       // bytes seen on miso
	logic [7:0] wr_vals [0:max_frame_bytes-1];      // payload for write frames
	int         seed;
	int         errors;

	spi_regs_top dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out)
	);

	always #2 sys_clk = ~sys_clk;                   // 4 ns period

	function automatic logic [7:0] next_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// map rules: 1..6 writable, everything else ignores writes
	function automatic void note_write(input logic [6:0] addr, input logic [7:0] data);
		if (addr >= addr_scratch_lo && addr <= addr_gpio_out)
			ref_regs[addr[2:0]] = data;
	endfunction

	function automatic logic [7:0] expected_read(input logic [6:0] addr);
		if (addr == addr_gpio_in)
			return gpio_in;                         // live pin
		else if (addr < reg_count)
			return ref_regs[addr[2:0]];
		return 8'h00;                               // unmapped
	endfunction

	task automatic expect_byte(input string sig, input logic [6:0] addr,
		input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp)
		else begin
			$display("[FAIL] %s addr=%h expected=%h actual=%h", sig, addr, exp, got);
			errors++;
		end
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// mode 3: drive on falling sclk, sample on rising sclk, msb first
	task automatic xfer_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		rx = 8'h00;
		for (int i = 7; i > 7 - nbits; i--) begin
			@(posedge sys_clk);
			sclk <= 1'b0;
			mosi <= tx[i];
			wait_clks(half_period - 1);
			@(negedge sys_clk);
			rx[i] = miso;                           // stable mid cycle
			@(posedge sys_clk);
			sclk <= 1'b1;
			wait_clks(half_period - 1);
		end
	endtask

	task automatic select_dev();
		@(posedge sys_clk);
		cs <= 1'b0;
		wait_clks(gap_cycles);                      // let the slave load tx
	endtask

	task automatic deselect_dev();
		wait_clks(gap_cycles);                      // last byte commits first
		@(posedge sys_clk);
		cs   <= 1'b1;
		mosi <= 1'b0;
		wait_clks(gap_cycles);
	endtask

	task automatic run_frame(input int nbytes);
		logic [7:0] rx;
		select_dev();
		for (int k = 0; k < nbytes; k++) begin
			xfer_bits(tx_buf[k], 8, rx);
			rx_buf[k] = rx;
		end
		deselect_dev();
	endtask

	task automatic write_regs(input logic [6:0] addr, input int n);
		tx_buf[0] = {1'b0, addr};
		for (int k = 0; k < n; k++)
			tx_buf[k + 1] = wr_vals[k];
		run_frame(n + 1);
		for (int k = 0; k < n; k++)
			note_write(addr + 7'(k), wr_vals[k]);
	endtask

	task automatic read_and_check(input logic [6:0] addr, input int n);
		tx_buf[0] = {1'b1, addr};
		for (int k = 1; k <= n; k++)
			tx_buf[k] = next_byte();                // filler, ignored by a read
		run_frame(n + 1);
		expect_byte("miso header slot", addr, 8'h00, rx_buf[0]);
		for (int k = 0; k < n; k++)
			expect_byte("miso", addr + 7'(k), expected_read(addr + 7'(k)), rx_buf[k + 1]);
	endtask

	// header plus half a data byte, then cs goes high
	task automatic abort_write(input logic [6:0] addr);
		logic [7:0] rx;
		select_dev();
		xfer_bits({1'b0, addr}, 8, rx);
		xfer_bits(next_byte(), 4, rx);
		deselect_dev();
	endtask

	initial begin
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		cs        = 1'b1;                           // deselected
		sclk      = 1'b1;                           // cpol 1 idle
		mosi      = 1'b0;
		gpio_in   = 8'h00;
		seed      = 32'h11c807d7;
		errors    = 0;
		for (int i = 0; i < reg_count; i++)
			ref_regs[i] = 8'h00;
		ref_regs[addr_id] = device_id;
		wait_clks(reset_cycles);
		sys_rst_n <= 1'b1;
		wait_clks(gap_cycles);

		// reset values, id then zeros
		read_and_check(addr_id, 7);

		// single writes with readback
		for (int a = addr_scratch_lo; a <= addr_scratch_hi; a++) begin
			wr_vals[0] = next_byte();
			write_regs(7'(a), 1);
			read_and_check(7'(a), 1);
		end

		// burst write 1..6, burst read 1..7
		for (int k = 0; k < 6; k++)
			wr_vals[k] = next_byte();
		write_regs(addr_scratch_lo, 6);
		read_and_check(addr_scratch_lo, 7);
		@(negedge sys_clk);
		expect_byte("gpio_out", addr_gpio_out, ref_regs[addr_gpio_out], gpio_out);

		// read-only registers
		@(posedge sys_clk);
		gpio_in <= next_byte();
		wr_vals[0] = next_byte();
		write_regs(addr_id, 1);
		wr_vals[0] = next_byte();
		write_regs(addr_gpio_in, 1);
		read_and_check(addr_id, 1);
		@(posedge sys_clk);
		gpio_in <= next_byte();                     // new pin value before readback
		read_and_check(addr_gpio_in, 1);

		// aborted frame and unmapped reads
		abort_write(7'd3);
		read_and_check(7'd3, 1);
		read_and_check(7'd8, 4);
		read_and_check(7'h40, 2);

		$display("checks failed: readback=%0d assertions=%0d",
			errors, dut.u_assertions.assert_errors);
		if (errors == 0 && dut.u_assertions.assert_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog, bound by frame count times longest frame
	initial begin
		wait_clks(timeout_cycles);
		$display("timeout: test sequence did not complete in %0d cycles", timeout_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- spi_regs_top.f
rtl/spi_regs_pkg.sv
rtl/spi_slave.sv
rtl/spi_frame_ctrl.sv
rtl/reg_bank.sv
rtl/spi_regs_top.sv
dv/spi_regs_assertions.sv
dv/tb_spi_regs.sv
